/* design/aluPkg.sv */
package aluPkg;

	// Operand width, results are twice as wide
	localparam int DataWidth = 32;

	// Opcode encodings shared with the sender
	typedef enum logic [4:0] {
		OpNot  = 5'b00001,
		OpAnd  = 5'b00010,
		OpOr   = 5'b00011,
		// Add group, bit 0 selects subtract and bit 1 selects negate
		OpAdd  = 5'b00100,
		OpSub  = 5'b00101,
		OpNeg  = 5'b00111,
		OpMul  = 5'b01000,
		OpDiv  = 5'b01001,
		// Shifts are 1 1 arith rotate right
		OpShl  = 5'b11000,
		OpShr  = 5'b11001,
		OpRol  = 5'b11010,
		OpRor  = 5'b11011,
		OpShla = 5'b11100,
		OpShra = 5'b11101
	} aluOpcode_e;

	// Field view of a shift opcode
	typedef struct packed {
		logic [1:0] shiftClass;
		logic       arith;
		logic       rotate;
		logic       right;
	} aluShiftOp_s;

	// The same five bits read either as an opcode or as shift fields
	typedef union packed {
		aluOpcode_e  opcode;
		aluShiftOp_s shift;
	} aluOp_u;

	// Request word from the sender
	typedef struct packed {
		aluOp_u                op;
		logic [DataWidth-1:0]  a;
		logic [DataWidth-1:0]  b;
	} aluReq_s;

	// Result word to the consumer, op is echoed from the request
	typedef struct packed {
		aluOp_u                  op;
		logic [2*DataWidth-1:0]  value;
	} aluRes_s;

endpackage

/* design/aluLogic.sv */
`timescale 1ns/1ps

module aluLogic (
	input  logic                             finished,
	input  logic                             rst,
	input  logic                             start,
	input  aluPkg::aluOp_u                   op,
	input  logic [aluPkg::DataWidth-1:0]     a,
	input  logic [aluPkg::DataWidth-1:0]     b,
	output logic                             done,
	output logic [2*aluPkg::DataWidth-1:0]   result
);

	logic                           subFlag;
	logic                           negFlag;
	logic [aluPkg::DataWidth-1:0]   addX;
	logic [aluPkg::DataWidth-1:0]   addY;
	logic [aluPkg::DataWidth-1:0]   sum;
	logic [aluPkg::DataWidth-1:0]   value;

	// Flags taken straight from the add group encoding
	assign subFlag = op.opcode[0];
	assign negFlag = op.opcode[1];

	// NEG is zero minus A, SUB is A plus inverted B plus one
	assign addX = negFlag ? '0 : a;
	assign addY = negFlag ? a : b;
	assign sum  = addX + (subFlag ? ~addY : addY) + {{(aluPkg::DataWidth-1){1'b0}}, subFlag};

	always_comb begin
		case (op.opcode)
			aluPkg::OpNot: value = ~a;
			aluPkg::OpAnd: value = a & b;
			aluPkg::OpOr:  value = a | b;
			default:       value = sum;
		endcase
	end

	always_ff @(posedge finished) begin
		if (rst) begin
			done <= 1'b0;
		end else begin
			done <= start;
		end
	end

	// Result holds until the next start
	always_ff @(posedge finished) begin
		if (start) begin
			result <= {{aluPkg::DataWidth{1'b0}}, value};
		end
	end

endmodule

/* design/aluShifter.sv */
`timescale 1ns/1ps

module aluShifter (
	input  logic                             finished,
	input  logic                             rst,
	input  logic                             start,
	input  aluPkg::aluOp_u                   op,
	input  logic [aluPkg::DataWidth-1:0]     a,
	input  logic [aluPkg::DataWidth-1:0]     b,
	output logic                             done,
	output logic [2*aluPkg::DataWidth-1:0]   result
);

	localparam int W = aluPkg::DataWidth;

	logic [4:0]    amount;
	logic          fill;
	logic [W-1:0]  aRev;
	logic [W-1:0]  outRev;
	logic [W-1:0]  stage [0:5];
	logic [W-1:0]  shifted;

	assign amount = b[4:0];
	// Sign fill only applies to right shifts, so SHLA acts as SHL
	assign fill = op.shift.arith & op.shift.right & a[W-1];

	// Left shifts run through the right shifter on bit-reversed data
	for (genvar i = 0; i < W; i++) begin : gReverse
		assign aRev[i]   = a[W-1-i];
		assign outRev[i] = stage[5][W-1-i];
	end

	assign stage[0] = op.shift.right ? a : aRev;

	for (genvar s = 0; s < 5; s++) begin : gStage
		localparam int Dist = 1 << s;
		assign stage[s+1] = !amount[s] ? stage[s] :
			op.shift.rotate ? {stage[s][Dist-1:0], stage[s][W-1:Dist]} :
			{{Dist{fill}}, stage[s][W-1:Dist]};
	end

	assign shifted = op.shift.right ? stage[5] : outRev;

	always_ff @(posedge finished) begin
		if (rst) begin
			done <= 1'b0;
		end else begin
			done <= start;
		end
	end

	always_ff @(posedge finished) begin
		if (start) begin
			result <= {{W{1'b0}}, shifted};
		end
	end

endmodule

/* design/aluMultiplier.sv */
`timescale 1ns/1ps

module aluMultiplier (
	input  logic                             finished,
	input  logic                             rst,
	input  logic                             start,
	input  logic [aluPkg::DataWidth-1:0]     a,
	input  logic [aluPkg::DataWidth-1:0]     b,
	output logic                             done,
	output logic [2*aluPkg::DataWidth-1:0]   result
);

	localparam int W = aluPkg::DataWidth;

	logic [5:0]      count;
	logic [2*W-1:0]  multiplicand;
	logic [W-1:0]    multiplier;
	logic [2*W-1:0]  product;

	// Count of remaining iterations, zero when idle
	always_ff @(posedge finished) begin
		if (rst) begin
			count <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				count <= 6'(W);
			end else if (count != '0) begin
				count <= count - 1'b1;
				// Last iteration lands on this edge
				done  <= (count == 6'd1);
			end
		end
	end

	// One multiplier bit per cycle, LSB first
	always_ff @(posedge finished) begin
		if (start) begin
			multiplicand <= {{W{1'b0}}, a};
			multiplier   <= b;
			product      <= '0;
		end else if (count != '0) begin
			if (multiplier[0]) begin
				product <= product + multiplicand;
			end
			multiplicand <= multiplicand << 1;
			multiplier   <= multiplier >> 1;
		end
	end

	assign result = product;

endmodule

/* design/aluDivider.sv */
`timescale 1ns/1ps

module aluDivider (
	input  logic                             finished,
	input  logic                             rst,
	input  logic                             start,
	input  logic [aluPkg::DataWidth-1:0]     a,
	input  logic [aluPkg::DataWidth-1:0]     b,
	output logic                             done,
	output logic [2*aluPkg::DataWidth-1:0]   result
);

	localparam int W = aluPkg::DataWidth;

	logic [5:0]    count;
	logic [W-1:0]  divisor;
	logic [W-1:0]  remainder;
	logic [W-1:0]  quotient;
	logic [W:0]    shiftedRem;
	logic [W+1:0]  trial;
	logic          quoBit;

	// Bring the next dividend bit into the partial remainder
	assign shiftedRem = {remainder, quotient[W-1]};

	// Trial subtract, a set top bit means the divisor did not fit
	assign trial  = {1'b0, shiftedRem} - {2'b00, divisor};
	assign quoBit = ~trial[W+1];

	always_ff @(posedge finished) begin
		if (rst) begin
			count <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				count <= 6'(W);
			end else if (count != '0) begin
				count <= count - 1'b1;
				done  <= (count == 6'd1);
			end
		end
	end

	// Dividend bits shift out of the quotient register as quotient bits shift in
	always_ff @(posedge finished) begin
		if (start) begin
			divisor   <= b;
			remainder <= '0;
			quotient  <= a;
		end else if (count != '0) begin
			// Restore by keeping the shifted value when the trial fails
			if (quoBit) begin
				remainder <= trial[W-1:0];
			end else begin
				remainder <= shiftedRem[W-1:0];
			end
			quotient <= {quotient[W-2:0], quoBit};
		end
	end

	// A zero divisor always fits, giving all ones and the dividend back
	assign result = {remainder, quotient};

endmodule

/* design/alu.sv */
`timescale 1ns/1ps

module alu #(
	parameter int QueueDepth    = 4,
	parameter int ResultCredits = 2
) (
	input  logic             finished,
	input  logic             rst,
	input  aluPkg::aluReq_s  req,
	input  logic             reqValid,
	output logic             reqCredit,
	output aluPkg::aluRes_s  res,
	output logic             resValid,
	input  logic             resCredit
);

	localparam int W           = aluPkg::DataWidth;
	localparam int PtrWidth    = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
	localparam int FillWidth   = $clog2(QueueDepth + 1);
	localparam int CreditWidth = $clog2(ResultCredits + 1);

	aluPkg::aluReq_s         queue [QueueDepth];
	logic [PtrWidth-1:0]     wrPtr;
	logic [PtrWidth-1:0]     rdPtr;
	logic [FillWidth-1:0]    fill;
	logic                    busy;
	logic [CreditWidth-1:0]  credits;
	aluPkg::aluReq_s         head;
	aluPkg::aluOp_u          activeOp;
	logic                    dispatch;
	logic                    isShift;
	logic                    isMul;
	logic                    isDiv;
	logic                    logicStart;
	logic                    shiftStart;
	logic                    mulStart;
	logic                    divStart;
	logic                    logicDone;
	logic                    shiftDone;
	logic                    mulDone;
	logic                    divDone;
	logic                    anyDone;
	logic [2*W-1:0]          logicResult;
	logic [2*W-1:0]          shiftResult;
	logic [2*W-1:0]          mulResult;
	logic [2*W-1:0]          divResult;
	logic [2*W-1:0]          doneResult;

	assign head = queue[rdPtr];

	// Pop needs an entry, an idle datapath and a result credit to reserve
	assign dispatch = (fill != '0) && !busy && (credits != '0);

	// Shift class first, then the two iterative units, the rest is logic
	assign isShift    = (head.op.shift.shiftClass == 2'b11);
	assign isMul      = (head.op.opcode == aluPkg::OpMul);
	assign isDiv      = (head.op.opcode == aluPkg::OpDiv);
	assign shiftStart = dispatch && isShift;
	assign mulStart   = dispatch && isMul;
	assign divStart   = dispatch && isDiv;
	assign logicStart = dispatch && !isShift && !isMul && !isDiv;

	// Request queue write side, the sender only sends with a credit in hand
	always_ff @(posedge finished) begin
		if (reqValid) begin
			queue[wrPtr] <= req;
		end
	end

	always_ff @(posedge finished) begin
		if (rst) begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			fill      <= '0;
			busy      <= 1'b0;
			credits   <= CreditWidth'(ResultCredits);
			reqCredit <= 1'b0;
		end else begin
			if (reqValid) begin
				wrPtr <= (wrPtr == PtrWidth'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (dispatch) begin
				rdPtr <= (rdPtr == PtrWidth'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			fill      <= fill + FillWidth'(reqValid) - FillWidth'(dispatch);
			credits   <= credits + CreditWidth'(resCredit) - CreditWidth'(dispatch);
			reqCredit <= dispatch;
			if (dispatch) begin
				busy <= 1'b1;
			end else if (anyDone) begin
				busy <= 1'b0;
			end
		end
	end

	// Op kept for the echo in the result word
	always_ff @(posedge finished) begin
		if (dispatch) begin
			activeOp <= head.op;
		end
	end

	aluLogic uLogic (
		.finished (finished),
		.rst      (rst),
		.start    (logicStart),
		.op       (head.op),
		.a        (head.a),
		.b        (head.b),
		.done     (logicDone),
		.result   (logicResult)
	);

	aluShifter uShifter (
		.finished (finished),
		.rst      (rst),
		.start    (shiftStart),
		.op       (head.op),
		.a        (head.a),
		.b        (head.b),
		.done     (shiftDone),
		.result   (shiftResult)
	);

	aluMultiplier uMultiplier (
		.finished (finished),
		.rst      (rst),
		.start    (mulStart),
		.a        (head.a),
		.b        (head.b),
		.done     (mulDone),
		.result   (mulResult)
	);

	aluDivider uDivider (
		.finished (finished),
		.rst      (rst),
		.start    (divStart),
		.a        (head.a),
		.b        (head.b),
		.done     (divDone),
		.result   (divResult)
	);

	// Only one unit runs at a time, so its done pulse selects it
	assign anyDone    = logicDone | shiftDone | mulDone | divDone;
	assign doneResult = shiftDone ? shiftResult :
		mulDone ? mulResult :
		divDone ? divResult : logicResult;

	always_ff @(posedge finished) begin
		if (rst) begin
			resValid <= 1'b0;
		end else begin
			resValid <= anyDone;
		end
	end

	always_ff @(posedge finished) begin
		if (anyDone) begin
			res.op    <= activeOp;
			res.value <= doneResult;
		end
	end

endmodule

/* sim/aluRef.svh */
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

// Expected result word for one request, written from the operation rules
function automatic aluPkg::aluRes_s expectedResult(aluPkg::aluReq_s r);
	aluPkg::aluRes_s want;
	logic [31:0]     a;
	logic [31:0]     b;
	int              sh;
	logic [31:0]     low;
	a = r.a;
	b = r.b;
	sh = int'(b[4:0]);
	low = '0;
	want.op = r.op;
	case (r.op.opcode)
		aluPkg::OpNot:  low = ~a;
		aluPkg::OpAnd:  low = a & b;
		aluPkg::OpOr:   low = a | b;
		aluPkg::OpAdd:  low = a + b;
		aluPkg::OpSub:  low = a - b;
		aluPkg::OpNeg:  low = 32'd0 - a;
		aluPkg::OpShl:  low = a << sh;
		aluPkg::OpShla: low = a << sh;
		aluPkg::OpShr:  low = a >> sh;
		aluPkg::OpShra: low = $unsigned($signed(a) >>> sh);
		// A shift by 32 yields zero, so amount 0 leaves A unchanged
		aluPkg::OpRol:  low = (a << sh) | (a >> (32 - sh));
		aluPkg::OpRor:  low = (a >> sh) | (a << (32 - sh));
		default:        low = '0;
	endcase
	want.value = {32'd0, low};
	if (r.op.opcode == aluPkg::OpMul) begin
		want.value = {32'd0, a} * {32'd0, b};
	end
	if (r.op.opcode == aluPkg::OpDiv) begin
		// Remainder on top, quotient below
		if (b == 32'd0) begin
			want.value = {a, 32'hFFFF_FFFF};
		end else begin
			want.value = {a % b, a / b};
		end
	end
	return want;
endfunction

`endif

/* sim/aluTb.sv */
`timescale 1ns/1ps

module aluTb #(
	parameter int Seed = 16629
);

	localparam int QueueDepth    = 4;
	localparam int ResultCredits = 2;

	logic             finished;
	logic             rst;
	aluPkg::aluReq_s  req;
	logic             reqValid;
	logic             reqCredit;
	aluPkg::aluRes_s  res;
	logic             resValid;
	logic             resCredit;

	aluPkg::aluReq_s  pending [$];
	aluPkg::aluRes_s  expected [$];
	aluPkg::aluReq_s  nextReq;
	aluPkg::aluRes_s  wantRes;
	int               seed;
	int               testCount = 0;
	int               creditsHeld = QueueDepth;
	int               sentCount = 0;
	int               returnedCount = 0;
	int               starvedCycles = 0;
	int               resultsSeen = 0;
	int               owed = 0;
	int               granted = 0;
	int               holdLeft = 0;
	real              watchdogLimit = 0.0;

	aluPkg::aluOpcode_e allOps [14] = '{aluPkg::OpNot, aluPkg::OpAnd, aluPkg::OpOr,
		aluPkg::OpAdd, aluPkg::OpSub, aluPkg::OpNeg, aluPkg::OpMul, aluPkg::OpDiv,
		aluPkg::OpShl, aluPkg::OpShr, aluPkg::OpRol, aluPkg::OpRor, aluPkg::OpShla,
		aluPkg::OpShra};
	aluPkg::aluOpcode_e shiftOps [6] = '{aluPkg::OpShl, aluPkg::OpShr, aluPkg::OpRol,
		aluPkg::OpRor, aluPkg::OpShla, aluPkg::OpShra};

	`include "aluRef.svh"

	alu #(
		.QueueDepth    (QueueDepth),
		.ResultCredits (ResultCredits)
	) u_alu (
		.finished  (finished),
		.rst       (rst),
		.req       (req),
		.reqValid  (reqValid),
		.reqCredit (reqCredit),
		.res       (res),
		.resValid  (resValid),
		.resCredit (resCredit)
	);

	initial begin
		finished = 1'b0;
		forever #50 finished = ~finished;
	end

	task automatic abortRun(string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "Run stopped after a failed check");
	endtask

	task automatic checkRes(aluPkg::aluRes_s want, aluPkg::aluRes_s got);
		if (got.op !== want.op) begin
			abortRun($sformatf("Error at %0t: res.op expected %h got %h",
				$time, want.op, got.op));
		end
		if (got.value !== want.value) begin
			abortRun($sformatf("Error at %0t: res.value (op %h) expected %h got %h",
				$time, want.op, want.value, got.value));
		end
	endtask

	task automatic checkCredits(string name, int want, int got);
		if (got != want) begin
			abortRun($sformatf("Error at %0t: %s expected %0d got %0d",
				$time, name, want, got));
		end
	endtask

	function automatic logic [31:0] randomWord();
		return $random(seed);
	endfunction

	function automatic int randomBelow(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	task automatic queueRequest(aluPkg::aluOpcode_e op, logic [31:0] a, logic [31:0] b);
		aluPkg::aluReq_s r;
		r.op.opcode = op;
		r.a = a;
		r.b = b;
		pending.push_back(r);
	endtask

	task automatic buildTests();
		logic [31:0] a;
		logic [31:0] b;
		queueRequest(aluPkg::OpNot, 32'hFFFF_FFFF, 32'h0);
		queueRequest(aluPkg::OpAnd, 32'hAAAA_AAAA, 32'h5555_5555);
		queueRequest(aluPkg::OpOr, 32'hAAAA_AAAA, 32'h5555_5555);
		queueRequest(aluPkg::OpAdd, 32'd15, 32'd25);
		queueRequest(aluPkg::OpSub, 32'd15, 32'd25);
		queueRequest(aluPkg::OpNeg, 32'd15, 32'd0);
		queueRequest(aluPkg::OpMul, 32'd24, 32'd8);
		queueRequest(aluPkg::OpDiv, 32'd24, 32'd8);
		// Upper bits of B stay random so only the low five may matter
		foreach (shiftOps[i]) begin
			for (int k = 0; k < 6; k++) begin
				a = randomWord();
				b = randomWord();
				if ((k % 2) == 1) begin
					a[31] = 1'b1;
				end
				case (k)
					0: b[4:0] = 5'd0;
					1: b[4:0] = 5'd1;
					2: b[4:0] = 5'd31;
					default: ;
				endcase
				queueRequest(shiftOps[i], a, b);
			end
		end
		queueRequest(aluPkg::OpShra, 32'h8000_0000, 32'd31);
		queueRequest(aluPkg::OpMul, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
		queueRequest(aluPkg::OpMul, randomWord() | 32'h8000_0000, randomWord() | 32'h8000_0000);
		queueRequest(aluPkg::OpDiv, randomWord(), randomWord() >> 16);
		queueRequest(aluPkg::OpDiv, randomWord(), 32'd0);
		queueRequest(aluPkg::OpDiv, 32'd5, 32'hFFFF_0000);
		queueRequest(aluPkg::OpDiv, 32'hFFFF_FFFF, 32'd1);
		// Mixed stream for ordering and back-pressure
		for (int n = 0; n < 300; n++) begin
			queueRequest(allOps[randomBelow(14)], randomWord(), randomWord());
		end
	endtask

	// Sender spends a credit per request and gets one back per reqCredit pulse
	always @(negedge finished) begin
		reqValid <= 1'b0;
		if (!rst) begin
			if (reqCredit) begin
				creditsHeld++;
				returnedCount++;
			end
			if (creditsHeld > QueueDepth) begin
				abortRun("reqCredit returned more credits than the queue holds");
			end
			if (pending.size() > 0 && creditsHeld > 0) begin
				nextReq = pending.pop_front();
				req <= nextReq;
				reqValid <= 1'b1;
				creditsHeld--;
				sentCount++;
				expected.push_back(expectedResult(nextReq));
			end
			if (creditsHeld == 0) begin
				starvedCycles++;
			end
		end
	end

	// Consumer returns one credit per result and sometimes pauses first
	always @(negedge finished) begin
		resCredit <= 1'b0;
		if (!rst) begin
			if (resValid) begin
				owed++;
				resultsSeen++;
			end
			if (resultsSeen > ResultCredits + granted) begin
				abortRun("resValid pulsed more often than result credits were granted");
			end
			if (holdLeft > 0) begin
				holdLeft--;
			end else if (owed > 0) begin
				resCredit <= 1'b1;
				owed--;
				granted++;
				if (randomBelow(4) == 0) begin
					holdLeft = 1 + randomBelow(12);
				end
			end
		end
	end

	always @(negedge finished) begin
		if (!rst && resValid) begin
			if (expected.size() == 0) begin
				abortRun("A result arrived while no request was outstanding");
			end else begin
				wantRes = expected.pop_front();
				checkRes(wantRes, res);
			end
		end
	end

	initial begin
		wait (watchdogLimit > 0.0);
		#(watchdogLimit);
		abortRun("Watchdog expired before all results arrived");
	end

	initial begin
		seed = Seed;
		rst <= 1'b1;
		req <= '0;
		reqValid <= 1'b0;
		resCredit <= 1'b0;
		buildTests();
		testCount = pending.size();
		// 40 cycles per request plus reset and half again as margin
		watchdogLimit = (real'(testCount) * 40.0 * 100.0 + 8.0 * 100.0) * 1.5;
		repeat (8) @(negedge finished);
		rst <= 1'b0;
		wait (resultsSeen == testCount);
		repeat (2) @(negedge finished);
		checkCredits("reqCredit pulses", sentCount, returnedCount);
		checkCredits("sender credits", QueueDepth, creditsHeld);
		if (starvedCycles == 0) begin
			abortRun("The sender never ran out of credits under result back-pressure");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

/* vlog.f */
+incdir+sim
design/aluPkg.sv
design/aluLogic.sv
design/aluShifter.sv
design/aluMultiplier.sv
design/aluDivider.sv
design/alu.sv
sim/aluTb.sv

/* Makefile */
# Verilator build and run for the ALU testbench

VERILATOR ?= verilator
TOP       ?= aluTb
RTL_TOP   ?= alu
SEED      ?= 16629
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSeed=$(SEED) -Mdir $(BUILD_DIR)

# A $fatal in the testbench gives a nonzero exit status
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
